// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = tb_apb_crc
FILELIST  = filelist.f
OBJ_DIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Test passed"

clean:
	rm -rf $(OBJ_DIR)

// ==== filelist.f ====
verilog/crc_pkg.sv
verilog/apb_regs_pkg.sv
verilog/apb_if.sv
verilog/crc_req_if.sv
verilog/apb_crc_regs.sv
verilog/crc32_engine.sv
verilog/crc_result_collect.sv
verilog/apb_crc_top.sv
sim/tb_apb_crc.sv

// ==== sim/tb_apb_crc.sv ====
// APB CRC-32 testbench
module tb_apb_crc
    import apb_regs_pkg::*;
;
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [1:0] OP_WR   = 2'd0;
    localparam logic [1:0] OP_RD   = 2'd1;
    localparam logic [1:0] OP_POLL = 2'd2;  // Wait for done with busy clear
    localparam logic [1:0] OP_IRQ  = 2'd3;

    typedef struct packed {
        logic [1:0] op;
        apb_addr_t  addr;
        apb_data_t  data;
        apb_data_t  exp;
        logic       use_model;  // Expect model CRC instead of exp
    } test_t;

    logic      clk_i;
    logic      rstn_i;
    apb_addr_t paddr;
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_data_t pwdata;
    apb_data_t prdata;
    logic      pready;
    logic      pslverr;
    logic      irq;

    test_t     tests[$];
    apb_data_t model_crc;  // Running value before final XOR
    integer    seed;
    int        errors;
    int        cycles;
    int        cycle_limit;

    apb_crc_top UUT (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .paddr_i   (paddr),
        .psel_i    (psel),
        .penable_i (penable),
        .pwrite_i  (pwrite),
        .pwdata_i  (pwdata),
        .prdata_o  (prdata),
        .pready_o  (pready),
        .pslverr_o (pslverr),
        .irq_o     (irq)
    );

    always #4 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
            $display("Test failed");
            $finish;
        end
    end

    // Reflected CRC-32 taking one data bit per step from the LSB
    function automatic apb_data_t crc32_word(apb_data_t crc, apb_data_t word);
        apb_data_t c;
        c = crc;
        for (int i = 0; i < 32; i++) begin
            if (c[0] ^ word[i]) begin
                c = (c >> 1) ^ 32'hEDB8_8320;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    task automatic check_value(input string name, input apb_data_t got, input apb_data_t exp);
        if (got !== exp) begin
            $display("error: %s is %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    // Called just after a falling edge
    task automatic apb_xfer(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
                            output apb_data_t data);
        paddr   = addr;
        pwrite  = wr;
        pwdata  = wdata;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk_i);
        penable = 1'b1;
        @(negedge clk_i);
        while (!pready) begin
            @(negedge clk_i);
        end
        data = prdata;
        check_value("pslverr", {31'b0, pslverr}, 32'h0);
        @(negedge clk_i);  // Completion edge is behind us
        psel    = 1'b0;
        penable = 1'b0;
        @(negedge clk_i);
    endtask

    task automatic poll_done();
        apb_data_t status;
        status = '0;
        while (!(status[STAT_DONE] && !status[STAT_BUSY])) begin
            apb_xfer(1'b0, apb_addr_t'(REG_STATUS), '0, status);
        end
    endtask

    task automatic add_test(input logic [1:0] op, input int addr, input apb_data_t data,
                            input apb_data_t exp, input logic use_model);
        test_t t;
        t.op        = op;
        t.addr      = apb_addr_t'(addr);
        t.data      = data;
        t.exp       = exp;
        t.use_model = use_model;
        tests.push_back(t);
    endtask

    task automatic build_table();
        apb_data_t w;
        add_test(OP_RD, REG_RESULT, '0, '0, 1'b0);
        add_test(OP_RD, REG_COUNT, '0, '0, 1'b0);
        add_test(OP_RD, REG_STATUS, '0, '0, 1'b0);
        add_test(OP_IRQ, 0, '0, '0, 1'b0);
        // Single word
        add_test(OP_WR, REG_CTRL, 32'h1, '0, 1'b0);
        add_test(OP_WR, REG_DATA, 32'h1234_5678, '0, 1'b0);
        add_test(OP_POLL, 0, '0, '0, 1'b0);
        add_test(OP_RD, REG_RESULT, '0, '0, 1'b1);
        add_test(OP_RD, REG_COUNT, '0, 32'd1, 1'b0);
        add_test(OP_RD, REG_STATUS, '0, 32'h2, 1'b0);
        // Three words and a new message that clears the count
        add_test(OP_WR, REG_CTRL, 32'h1, '0, 1'b0);
        add_test(OP_WR, REG_DATA, 32'hDEAD_BEEF, '0, 1'b0);
        add_test(OP_POLL, 0, '0, '0, 1'b0);
        add_test(OP_WR, REG_DATA, 32'h0000_0000, '0, 1'b0);
        add_test(OP_POLL, 0, '0, '0, 1'b0);
        add_test(OP_WR, REG_DATA, 32'hFFFF_FFFF, '0, 1'b0);
        add_test(OP_POLL, 0, '0, '0, 1'b0);
        add_test(OP_RD, REG_RESULT, '0, '0, 1'b1);
        add_test(OP_RD, REG_COUNT, '0, 32'd3, 1'b0);
        add_test(OP_WR, REG_CTRL, 32'h1, '0, 1'b0);
        add_test(OP_RD, REG_COUNT, '0, '0, 1'b0);
        add_test(OP_RD, REG_STATUS, '0, '0, 1'b0);
        // Back-to-back writes stalled by pready
        add_test(OP_WR, REG_DATA, 32'h0102_0304, '0, 1'b0);
        add_test(OP_WR, REG_DATA, 32'hA5A5_5A5A, '0, 1'b0);
        add_test(OP_WR, REG_DATA, 32'h8000_0001, '0, 1'b0);
        add_test(OP_WR, REG_DATA, 32'h3C3C_C3C3, '0, 1'b0);
        add_test(OP_POLL, 0, '0, '0, 1'b0);
        add_test(OP_RD, REG_RESULT, '0, '0, 1'b1);
        add_test(OP_RD, REG_COUNT, '0, 32'd4, 1'b0);
        // Interrupt with enable set and then clear
        add_test(OP_WR, REG_CTRL, 32'h3, '0, 1'b0);
        add_test(OP_WR, REG_DATA, 32'h0BAD_F00D, '0, 1'b0);
        add_test(OP_POLL, 0, '0, '0, 1'b0);
        add_test(OP_IRQ, 0, '0, 32'd1, 1'b0);
        add_test(OP_WR, REG_CTRL, 32'h3, '0, 1'b0);
        add_test(OP_IRQ, 0, '0, '0, 1'b0);
        add_test(OP_WR, REG_CTRL, 32'h1, '0, 1'b0);
        add_test(OP_WR, REG_DATA, 32'h7777_1111, '0, 1'b0);
        add_test(OP_POLL, 0, '0, '0, 1'b0);
        add_test(OP_IRQ, 0, '0, '0, 1'b0);
        // Eight random words
        add_test(OP_WR, REG_CTRL, 32'h1, '0, 1'b0);
        for (int i = 0; i < 8; i++) begin
            w = $random(seed);
            add_test(OP_WR, REG_DATA, w, '0, 1'b0);
        end
        add_test(OP_POLL, 0, '0, '0, 1'b0);
        add_test(OP_RD, REG_RESULT, '0, '0, 1'b1);
        add_test(OP_RD, REG_COUNT, '0, 32'd8, 1'b0);
    endtask

    task automatic run_test(input int idx);
        test_t     t;
        apb_data_t rdata;
        apb_data_t exp_val;
        int        errs_before;
        t           = tests[idx];
        errs_before = errors;
        case (t.op)
            OP_WR: begin
                apb_xfer(1'b1, t.addr, t.data, rdata);
                if (t.addr == apb_addr_t'(REG_CTRL) && t.data[CTRL_NEW_MSG]) begin
                    model_crc = 32'hFFFF_FFFF;
                end else if (t.addr == apb_addr_t'(REG_DATA)) begin
                    model_crc = crc32_word(model_crc, t.data);
                end
            end
            OP_RD: begin
                apb_xfer(1'b0, t.addr, '0, rdata);
                exp_val = t.use_model ? (model_crc ^ 32'hFFFF_FFFF) : t.exp;
                check_value("prdata", rdata, exp_val);
            end
            OP_POLL: poll_done();
            default: check_value("irq_o", {31'b0, irq}, t.exp);
        endcase
        $display("test %0d op %0d addr %h: %s", idx, t.op, t.addr,
                 (errors == errs_before) ? "ok" : "mismatch");
    endtask

    initial begin
        clk_i     = 1'b0;
        rstn_i    = 1'b0;
        paddr     = '0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        pwdata    = '0;
        seed      = 44738;
        errors    = 0;
        cycles    = 0;
        model_crc = 32'hFFFF_FFFF;  // Engine starts a fresh message after reset
        build_table();
        cycle_limit = 40 * tests.size() + 100;
        repeat (2) @(negedge clk_i);
        rstn_i = 1'b1;
        for (int i = 0; i < tests.size(); i++) begin
            run_test(i);
        end
        $display("%0d tests run, %0d errors", tests.size(), errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== verilog/apb_crc_regs.sv ====
// APB register file for CRC unit
module apb_crc_regs
    import apb_regs_pkg::*;
(
    input  logic      clk_i,
    input  logic      rstn_i,
    apb_if.slave      s_apb,
    crc_req_if.src    req,
    input  rd_regs_t  rd_regs_i,
    input  rd_valid_t rd_valid_i,
    output logic      new_msg_o,
    output logic      irq_en_o
);

    logic [WR_REG_NUM-1:0] wr_sel;
    logic                  access;
    logic                  stall;
    logic                  accept;
    logic                  write;
    logic                  read;
    logic                  ctrl_wr;
    logic                  data_wr;
    logic                  first_pending;

    rd_regs_t  rd_regs_q;
    rd_valid_t rd_valid_q;
    rd_regs_t  rd_bank;

    assign s_apb.pslverr = 1'b0;

    always_comb begin
        for (int i = 0; i < WR_REG_NUM; i++) begin
            wr_sel[i] = (s_apb.paddr == apb_addr_t'(i * ADDR_OFFSET));
        end
    end

    assign access = s_apb.psel & s_apb.penable;
    // Hold off DATA writes until the previous handshake is over
    assign stall  = s_apb.pwrite & wr_sel[REG_DATA / ADDR_OFFSET] & (req.req | req.ack);
    assign accept = access & ~s_apb.pready & ~stall;
    assign write  = accept & s_apb.pwrite;
    assign read   = accept & ~s_apb.pwrite;

    assign ctrl_wr = write & wr_sel[REG_CTRL / ADDR_OFFSET];
    assign data_wr = write & wr_sel[REG_DATA / ADDR_OFFSET];

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            s_apb.pready  <= 1'b0;
            req.req       <= 1'b0;
            req.first     <= 1'b0;
            new_msg_o     <= 1'b0;
            irq_en_o      <= 1'b0;
            first_pending <= 1'b1;  // Fresh message after reset
        end else begin
            s_apb.pready <= accept;
            new_msg_o    <= 1'b0;
            if (ctrl_wr) begin
                irq_en_o  <= s_apb.pwdata[CTRL_IRQ_EN];
                new_msg_o <= s_apb.pwdata[CTRL_NEW_MSG];
                if (s_apb.pwdata[CTRL_NEW_MSG]) begin
                    first_pending <= 1'b1;
                end
            end
            if (data_wr) begin
                req.req       <= 1'b1;
                req.first     <= first_pending;
                first_pending <= 1'b0;
            end else if (req.ack) begin
                req.req <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (data_wr) begin
            req.word <= s_apb.pwdata;
        end
    end

    // Read-back path through one register stage into the bank
    always_ff @(posedge clk_i) begin
        rd_regs_q <= rd_regs_i;
        if (!rstn_i) begin
            rd_valid_q <= '0;
            rd_bank    <= '0;
        end else begin
            rd_valid_q <= rd_valid_i;
            for (int i = 0; i < RD_REG_NUM; i++) begin
                if (rd_valid_q[i]) begin
                    rd_bank[i] <= rd_regs_q[i];
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (read) begin
            s_apb.prdata <= '0;  // Unmapped reads give zero
            for (int i = 0; i < RD_REG_NUM; i++) begin
                if (s_apb.paddr == apb_addr_t'(i * ADDR_OFFSET)) begin
                    s_apb.prdata <= rd_bank[i];
                end
            end
        end
    end

    a_req_hold: assert property (@(posedge clk_i) disable iff (!rstn_i)
        req.req && !req.ack |=> req.req && $stable(req.word) && $stable(req.first));

endmodule

// ==== verilog/apb_crc_top.sv ====
// APB CRC-32 peripheral
module apb_crc_top
    import apb_regs_pkg::*;
(
    input  logic      clk_i,
    input  logic      rstn_i,
    input  apb_addr_t paddr_i,
    input  logic      psel_i,
    input  logic      penable_i,
    input  logic      pwrite_i,
    input  apb_data_t pwdata_i,
    output apb_data_t prdata_o,
    output logic      pready_o,
    output logic      pslverr_o,
    output logic      irq_o
);

    apb_if     apb_bus ();
    crc_req_if crc_req ();

    rd_regs_t  rd_regs;
    rd_valid_t rd_valid;
    logic      new_msg;
    logic      irq_en;

    // Master side from the pins
    assign apb_bus.paddr   = paddr_i;
    assign apb_bus.psel    = psel_i;
    assign apb_bus.penable = penable_i;
    assign apb_bus.pwrite  = pwrite_i;
    assign apb_bus.pwdata  = pwdata_i;
    assign prdata_o        = apb_bus.prdata;
    assign pready_o        = apb_bus.pready;
    assign pslverr_o       = apb_bus.pslverr;

    apb_crc_regs u_regs (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .s_apb      (apb_bus.slave),
        .req        (crc_req.src),
        .rd_regs_i  (rd_regs),
        .rd_valid_i (rd_valid),
        .new_msg_o  (new_msg),
        .irq_en_o   (irq_en)
    );

    crc32_engine u_engine (.clk_i(clk_i), .rstn_i(rstn_i), .req(crc_req.dst));

    crc_result_collect u_collect (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .mon        (crc_req.mon),
        .new_msg_i  (new_msg),
        .irq_en_i   (irq_en),
        .rd_regs_o  (rd_regs),
        .rd_valid_o (rd_valid),
        .irq_o      (irq_o)
    );

endmodule

// ==== verilog/apb_if.sv ====
// APB bus
interface apb_if
    import apb_regs_pkg::*;
();

    apb_addr_t paddr;
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_data_t pwdata;
    apb_data_t prdata;
    logic      pready;
    logic      pslverr;

    modport master(
        output paddr, psel, penable, pwrite, pwdata,
        input prdata, pready, pslverr
    );

    modport slave(
        input paddr, psel, penable, pwrite, pwdata,
        output prdata, pready, pslverr
    );

endinterface

// ==== verilog/apb_regs_pkg.sv ====
// APB register map
package apb_regs_pkg;

    localparam int APB_ADDR_WIDTH = 12;
    localparam int APB_DATA_WIDTH = 32;
    localparam int WR_REG_NUM     = 2;
    localparam int RD_REG_NUM     = 3;
    localparam int ADDR_OFFSET    = APB_DATA_WIDTH / 8;

    // Write side
    localparam int REG_CTRL   = 0;
    localparam int REG_DATA   = 4;
    // Read side
    localparam int REG_RESULT = 0;
    localparam int REG_COUNT  = 4;
    localparam int REG_STATUS = 8;

    localparam int CTRL_NEW_MSG = 0;
    localparam int CTRL_IRQ_EN  = 1;
    localparam int STAT_BUSY    = 0;
    localparam int STAT_DONE    = 1;

    typedef logic [APB_ADDR_WIDTH-1:0] apb_addr_t;
    typedef logic [APB_DATA_WIDTH-1:0] apb_data_t;
    typedef logic [RD_REG_NUM-1:0][APB_DATA_WIDTH-1:0] rd_regs_t;
    typedef logic [RD_REG_NUM-1:0] rd_valid_t;
    typedef logic [15:0] word_cnt_t;

endpackage

// ==== verilog/crc32_engine.sv ====
// Byte-serial CRC-32 engine
module crc32_engine
    import crc_pkg::*;
(
    input logic    clk_i,
    input logic    rstn_i,
    crc_req_if.dst req
);

    engine_state_t state;
    crc_t          crc_q;
    crc_word_t     word_q;
    byte_cnt_t     byte_idx;

    function automatic crc_t crc_byte(crc_t crc_in, logic [BYTE_WIDTH-1:0] data);
        crc_t c;
        c = crc_in ^ crc_t'(data);
        for (int b = 0; b < BYTE_WIDTH; b++) begin
            c = c[0] ? ((c >> 1) ^ CRC_POLY) : (c >> 1);
        end
        return c;
    endfunction

    assign req.result = crc_q;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state    <= IDLE;
            req.ack  <= 1'b0;
            crc_q    <= CRC_INIT;
            byte_idx <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (req.req) begin
                        crc_q    <= req.first ? CRC_INIT : crc_q;
                        byte_idx <= '0;
                        state    <= SHIFT;
                    end
                end
                SHIFT: begin
                    crc_q    <= crc_byte(crc_q, word_q[BYTE_WIDTH-1:0]);  // LSB first
                    byte_idx <= byte_idx + 1'b1;
                    if (byte_idx == byte_cnt_t'(BYTES_PER_WORD - 1)) begin
                        req.ack <= 1'b1;
                        state   <= ACK;
                    end
                end
                ACK: begin
                    if (!req.req) begin
                        req.ack <= 1'b0;
                        state   <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state == IDLE && req.req) begin
            word_q <= req.word;
        end else if (state == SHIFT) begin
            word_q <= word_q >> BYTE_WIDTH;
        end
    end

    a_ack_needs_req: assert property (@(posedge clk_i) disable iff (!rstn_i)
        $rose(req.ack) |-> req.req);

endmodule

// ==== verilog/crc_pkg.sv ====
// CRC-32 definitions
package crc_pkg;

    localparam int CRC_WIDTH      = 32;
    localparam int BYTE_WIDTH     = 8;
    localparam int BYTES_PER_WORD = 4;

    typedef logic [CRC_WIDTH-1:0] crc_t;
    typedef logic [BYTES_PER_WORD*BYTE_WIDTH-1:0] crc_word_t;
    typedef logic [$clog2(BYTES_PER_WORD)-1:0] byte_cnt_t;

    // Reflected form of 04C11DB7
    localparam crc_t CRC_POLY    = 32'hEDB8_8320;
    localparam crc_t CRC_INIT    = 32'hFFFF_FFFF;
    localparam crc_t CRC_XOR_OUT = 32'hFFFF_FFFF;

    typedef enum logic [1:0] {
        IDLE,
        SHIFT,  // One byte per cycle
        ACK
    } engine_state_t;

endpackage

// ==== verilog/crc_req_if.sv ====
// Word request handshake
interface crc_req_if
    import crc_pkg::*;
();

    logic      req;
    logic      ack;
    crc_word_t word;
    logic      first;   // Restart from CRC_INIT
    crc_t      result;  // Running value before final XOR

    modport src(
        output req, word, first,
        input ack, result
    );

    modport dst(
        input req, word, first,
        output ack, result
    );

    modport mon(
        input req, ack, word, first, result
    );

endinterface

// ==== verilog/crc_result_collect.sv ====
// CRC result and status collector
module crc_result_collect
    import crc_pkg::*;
    import apb_regs_pkg::*;
(
    input  logic      clk_i,
    input  logic      rstn_i,
    crc_req_if.mon    mon,
    input  logic      new_msg_i,
    input  logic      irq_en_i,
    output rd_regs_t  rd_regs_o,
    output rd_valid_t rd_valid_o,
    output logic      irq_o
);

    logic      ack_d;
    logic      ack_rise;
    crc_t      crc_q;
    word_cnt_t count_q;
    logic      done_q;
    rd_regs_t  rd_cur;
    rd_regs_t  rd_prev;

    assign ack_rise = mon.ack & ~ack_d;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            ack_d   <= 1'b0;
            crc_q   <= '0;
            count_q <= '0;
            done_q  <= 1'b0;
            irq_o   <= 1'b0;
            rd_prev <= '0;
        end else begin
            ack_d   <= mon.ack;
            rd_prev <= rd_cur;
            irq_o   <= new_msg_i ? 1'b0 : (done_q & irq_en_i);
            if (new_msg_i) begin
                count_q <= '0;
                done_q  <= 1'b0;
            end else if (ack_rise) begin
                crc_q   <= mon.result ^ CRC_XOR_OUT;
                count_q <= count_q + 1'b1;
                done_q  <= 1'b1;
            end
        end
    end

    always_comb begin
        rd_cur = '0;
        rd_cur[REG_RESULT / ADDR_OFFSET] = crc_q;
        rd_cur[REG_COUNT / ADDR_OFFSET][$bits(word_cnt_t)-1:0] = count_q;
        rd_cur[REG_STATUS / ADDR_OFFSET][STAT_BUSY] = mon.req | mon.ack;
        rd_cur[REG_STATUS / ADDR_OFFSET][STAT_DONE] = done_q;
    end

    assign rd_regs_o = rd_cur;

    always_comb begin
        for (int i = 0; i < RD_REG_NUM; i++) begin
            rd_valid_o[i] = (rd_cur[i] != rd_prev[i]);  // Strobe on change
        end
    end

    a_count_cause: assert property (@(posedge clk_i) disable iff (!rstn_i)
        $changed(count_q) |-> $past(new_msg_i | (ack_rise & mon.req)));

endmodule
